/* fetch_frontend.f */
hdl/fetch_pkg.sv
hdl/fifo_generator.sv
hdl/if1_stage.sv
hdl/fetch_frontend.sv
verification/tb_clock.sv
verification/fetch_checker.sv
verification/fetch_frontend_tb.sv

/* hdl/fetch_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend #(
    parameter logic [31:0] reset_pc = 32'h1c00_0000,
    parameter int pc_depth = 4,
    parameter int iq_depth = 8
) (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire logic                        flush,
    input  wire logic [31:0]                 redirect_pc,
    input  wire logic                        resp_valid,
    input  wire fetch_pkg::icache_resp_t     resp,
    input  wire logic                        pop,
    output logic                             req_valid,
    output fetch_pkg::fetch_req_t            fetch_req,
    output logic                             bundle_valid,
    output fetch_pkg::fetch_bundle_t         bundle
);

    localparam int bundle_w = $bits(fetch_pkg::fetch_bundle_t);

    // tracking fifo side
    logic        pc_push;
    logic        pc_pop;
    logic [31:0] tracked_pc;
    logic        pc_empty;
    logic        pc_full;

    // instruction queue side
    logic                             iq_push;
    fetch_pkg::fetch_bundle_t         iq_bundle;
    logic [$clog2(iq_depth+1)-1:0]    iq_free;
    logic                             iq_empty;
    logic                             iq_pop;

    if1_stage #(
        .reset_pc (reset_pc),
        .pc_depth (pc_depth),
        .iq_depth (iq_depth)
    ) u_if1_stage (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .tracked_pc  (tracked_pc),
        .pc_empty    (pc_empty),
        .pc_full     (pc_full),
        .iq_free     (iq_free),
        .req_valid   (req_valid),
        .fetch_req   (fetch_req),
        .pc_push     (pc_push),
        .pc_pop      (pc_pop),
        .iq_push     (iq_push),
        .iq_bundle   (iq_bundle)
    );

    // requested pcs, oldest at the head
    fifo_generator #(
        .data_width (32),
        .depth      (pc_depth)
    ) u_pc_queue (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .push       (pc_push),
        .din        (fetch_req.pc),
        .pop        (pc_pop),
        .dout       (tracked_pc),
        .empty      (pc_empty),
        .full       (pc_full),
        .free_count ()
    );

    // decoder consumes from here
    assign bundle_valid = !iq_empty;
    assign iq_pop = pop && bundle_valid;

    fifo_generator #(
        .data_width (bundle_w),
        .depth      (iq_depth)
    ) u_inst_queue (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .push       (iq_push),
        .din        (iq_bundle),
        .pop        (iq_pop),
        .dout       (bundle),
        .empty      (iq_empty),
        .full       (),
        .free_count (iq_free)
    );

endmodule

`default_nettype wire

/* hdl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // nop used to fill an empty slot
    // andi r0, r0, 0
    localparam logic [31:0] inst_nop = 32'h0340_0000;

    // fetch block is two words, 8 bytes
    localparam int unsigned fetch_bytes = 8;

    // request to the instruction cache
    // cache uses pc[31:3] to pick the 8-byte block
    // low bits ride along so the tracked pc keeps the slot offset
    typedef struct packed {
        logic [31:0] pc;
    } fetch_req_t;

    // one cache response, in request order
    typedef struct packed {
        // word at block offset 0
        logic [31:0] inst0;
        // word at block offset 4
        logic [31:0] inst1;
        // faulting address
        logic [31:0] badv;
        // exception code, shared by both words
        logic [6:0]  excp_code;
        // one flag per word, bit 0 is inst0
        logic [1:0]  excp_flag;
    } icache_resp_t;

    // one instruction queue entry for the decoder
    typedef struct packed {
        // pc of slot 0
        logic [31:0] pc;
        // slot 0 word
        logic [31:0] inst0;
        // slot 1 word, nop when unused
        logic [31:0] inst1;
        // bit 0 slot 0, bit 1 slot 1
        logic [1:0]  slot_valid;
        logic [31:0] badv;
        logic [6:0]  excp_code;
        // already shifted to match the slots
        logic [1:0]  excp_flag;
    } fetch_bundle_t;

endpackage

`default_nettype wire

/* hdl/fifo_generator.sv */
`timescale 1ns/100ps
`default_nettype none

module fifo_generator #(
    parameter int data_width = 32,
    parameter int depth = 4
) (
    input  wire logic                          clk,
    input  wire logic                          rstn,
    input  wire logic                          flush,
    input  wire logic                          push,
    input  wire logic [data_width-1:0]         din,
    input  wire logic                          pop,
    output logic      [data_width-1:0]         dout,
    output logic                               empty,
    output logic                               full,
    output logic      [$clog2(depth+1)-1:0]    free_count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    // payload storage
    logic [data_width-1:0] mem [depth];
    logic [data_width-1:0] head_q;

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr_next;
    logic [ptr_w-1:0] wr_ptr_next;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_next;
    logic             head_from_din;

    // pointer wrap
    // depth need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_comb begin
        rd_ptr_next = pop ? ptr_inc(rd_ptr) : rd_ptr;
        wr_ptr_next = push ? ptr_inc(wr_ptr) : wr_ptr;
        count_next = count + cnt_w'(push) - cnt_w'(pop);
    end

    // new head is the entry being written this cycle
    // only happens when nothing older is left after the pop
    assign head_from_din = push && (wr_ptr == rd_ptr_next);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            rd_ptr <= rd_ptr_next;
            wr_ptr <= wr_ptr_next;
            count <= count_next;
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= din;
        end
    end

    // registered head
    // garbage while empty
    always_ff @(posedge clk) begin
        if (head_from_din) begin
            head_q <= din;
        end else begin
            head_q <= mem[rd_ptr_next];
        end
    end

    assign dout = head_q;
    assign empty = (count == '0);
    assign full = (count == cnt_w'(depth));
    assign free_count = cnt_w'(depth) - count;

    // no push into a full buffer
    // a same-cycle pop makes room
    a_no_overflow : assert property (@(posedge clk) disable iff (!rstn)
        (push && !flush) |-> (!full || pop));

    // underflow
    a_no_underflow : assert property (@(posedge clk) disable iff (!rstn)
        (pop && !flush) |-> !empty);

endmodule

`default_nettype wire

/* hdl/if1_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module if1_stage #(
    parameter logic [31:0] reset_pc = 32'h1c00_0000,
    parameter int pc_depth = 4,
    parameter int iq_depth = 8
) (
    input  wire logic                               clk,
    input  wire logic                               rstn,
    input  wire logic                               flush,
    input  wire logic [31:0]                        redirect_pc,
    input  wire logic                               resp_valid,
    input  wire fetch_pkg::icache_resp_t            resp,
    input  wire logic [31:0]                        tracked_pc,
    input  wire logic                               pc_empty,
    input  wire logic                               pc_full,
    input  wire logic [$clog2(iq_depth+1)-1:0]      iq_free,
    output logic                                    req_valid,
    output fetch_pkg::fetch_req_t                   fetch_req,
    output logic                                    pc_push,
    output logic                                    pc_pop,
    output logic                                    iq_push,
    output fetch_pkg::fetch_bundle_t                iq_bundle
);

    localparam int out_w = $clog2(pc_depth + 1);

    // fetch pc, low bits kept for the slot offset
    logic [31:0] fetch_pc;
    logic [31:0] fetch_pc_next;

    // requests sent and not yet answered
    logic [out_w-1:0] outstanding;

    logic credit_ok;
    logic resp_take;
    logic upper_only;

    // request credit
    // every outstanding request needs its own queue entry,
    // plus one for the request made now
    assign credit_ok = !flush && !pc_full && (int'(iq_free) > int'(outstanding));
    assign req_valid = credit_ok;

    assign fetch_req.pc = fetch_pc;

    // next block, aligned then plus 8
    assign fetch_pc_next = {fetch_pc[31:3], 3'b000} + 32'(fetch_pkg::fetch_bytes);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_pc <= reset_pc;
        end else if (flush) begin
            fetch_pc <= redirect_pc;
        end else if (req_valid) begin
            fetch_pc <= fetch_pc_next;
        end
    end

    // outstanding count
    // up on request, down on response, both can happen together
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            outstanding <= '0;
        end else if (flush) begin
            // cache drops everything older than the flush
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + out_w'(req_valid) - out_w'(resp_take);
        end
    end

    // track every requested pc
    assign pc_push = req_valid;

    // response in the flush cycle belongs to the old stream
    assign resp_take = resp_valid && !flush;
    assign pc_pop = resp_take;
    assign iq_push = resp_take;

    // pc in the upper half of the block
    // slot 0 starts at inst1
    assign upper_only = tracked_pc[2];

    always_comb begin
        iq_bundle.pc = tracked_pc;
        iq_bundle.badv = resp.badv;
        iq_bundle.excp_code = resp.excp_code;
        if (upper_only) begin
            iq_bundle.inst0 = resp.inst1;
            iq_bundle.inst1 = fetch_pkg::inst_nop;
            iq_bundle.slot_valid = 2'b01;
            // upper flag moves down with its word
            iq_bundle.excp_flag = {1'b0, resp.excp_flag[1]};
        end else begin
            iq_bundle.inst0 = resp.inst0;
            iq_bundle.inst1 = resp.inst1;
            iq_bundle.slot_valid = 2'b11;
            iq_bundle.excp_flag = resp.excp_flag;
        end
    end

    // every response must pair with a tracked pc
    a_resp_has_pc : assert property (@(posedge clk) disable iff (!rstn)
        resp_take |-> !pc_empty);

    // credit must leave room for every response
    a_iq_has_room : assert property (@(posedge clk) disable iff (!rstn)
        iq_push |-> (iq_free != '0));

endmodule

`default_nettype wire

/* verification/fetch_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_checker #(
    parameter logic [31:0] reset_pc = 32'h1c00_0000,
    parameter int pc_depth = 4,
    parameter int iq_depth = 8
) (
    input  wire logic                      clk,
    input  wire logic                      rstn,
    input  wire logic                      flush,
    input  wire logic [31:0]               redirect_pc,
    input  wire logic                      resp_valid,
    input  wire fetch_pkg::icache_resp_t   resp,
    input  wire logic                      pop,
    input  wire logic                      req_valid,
    input  wire fetch_pkg::fetch_req_t     fetch_req,
    input  wire logic                      bundle_valid,
    input  wire fetch_pkg::fetch_bundle_t  bundle,
    output int                             error_count,
    output int                             bundle_count,
    output int                             request_count
);

    // next pc the frontend should ask for
    logic [31:0] exp_pc;
    // requested pcs still waiting for the cache
    logic [31:0] req_pcs[$];
    // bundles expected in the queue, oldest first
    fetch_pkg::fetch_bundle_t exp_bundles[$];
    logic exp_credit;
    int errors = 0;
    int bundles = 0;
    int requests = 0;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // entry built from the requested pc and the two cache words
    function automatic fetch_pkg::fetch_bundle_t expect_bundle(
        input logic [31:0] pc, input fetch_pkg::icache_resp_t r);
        fetch_pkg::fetch_bundle_t b;
        logic [31:0] words [2];
        logic first;
        words[0] = r.inst0;
        words[1] = r.inst1;
        // pc bit 2 picks the first word used
        first = pc[2];
        b.pc = pc;
        b.inst0 = words[first];
        b.inst1 = first ? fetch_pkg::inst_nop : words[1];
        b.slot_valid = first ? 2'b01 : 2'b11;
        // flags follow their words down
        b.excp_flag = r.excp_flag >> first;
        b.badv = r.badv;
        b.excp_code = r.excp_code;
        return b;
    endfunction

    task automatic compare_bundle(input fetch_pkg::fetch_bundle_t exp);
        check_value("bundle.pc", exp.pc, bundle.pc);
        check_value("bundle.inst0", exp.inst0, bundle.inst0);
        check_value("bundle.inst1", exp.inst1, bundle.inst1);
        check_value("bundle.slot_valid", 32'(exp.slot_valid), 32'(bundle.slot_valid));
        check_value("bundle.badv", exp.badv, bundle.badv);
        check_value("bundle.excp_code", 32'(exp.excp_code), 32'(bundle.excp_code));
        check_value("bundle.excp_flag", 32'(exp.excp_flag), 32'(bundle.excp_flag));
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            exp_pc = reset_pc;
            req_pcs.delete();
            exp_bundles.delete();
        end else if (flush) begin
            check_value("req_valid", 32'd0, 32'(req_valid));
            // old stream is gone, restart at the redirect
            exp_pc = redirect_pc;
            req_pcs.delete();
            exp_bundles.delete();
        end else begin
            // credit, room for every outstanding answer plus this one
            exp_credit = (req_pcs.size() < pc_depth) &&
                         (iq_depth - exp_bundles.size() > req_pcs.size());
            check_value("req_valid", 32'(exp_credit), 32'(req_valid));
            check_value("bundle_valid", 32'(exp_bundles.size() != 0), 32'(bundle_valid));
            if (pop && bundle_valid) begin
                if (exp_bundles.size() == 0) begin
                    $display("error at %0t: a bundle was popped but none was expected", $time);
                    errors++;
                end else begin
                    compare_bundle(exp_bundles.pop_front());
                    bundles++;
                end
            end
            if (req_valid) begin
                check_value("fetch_req.pc", exp_pc, fetch_req.pc);
                req_pcs.push_back(exp_pc);
                exp_pc = {exp_pc[31:3], 3'b000} + 32'd8;
                requests++;
            end
            if (resp_valid) begin
                if (req_pcs.size() == 0) begin
                    $display("error at %0t: cache answered with no request outstanding", $time);
                    errors++;
                end else begin
                    exp_bundles.push_back(expect_bundle(req_pcs.pop_front(), resp));
                end
            end
            if (exp_bundles.size() > iq_depth) begin
                $display("error at %0t: instruction queue asked to hold more than it can", $time);
                errors++;
            end
        end
        error_count <= errors;
        bundle_count <= bundles;
        request_count <= requests;
    end

endmodule

`default_nettype wire

/* verification/fetch_frontend_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend_tb;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;
    localparam int pc_depth = 4;
    localparam int iq_depth = 8;

    // bundles popped per test
    localparam int n_start = 24;
    localparam int n_redirect = 16;
    localparam int n_random = 200;
    localparam int n_stall = 32;
    localparam int n_flush = 24;
    localparam int total_bundles = n_start + n_redirect + n_random + n_stall + n_flush;
    localparam int cycle_limit = 20 * total_bundles + 200;

    logic                      clk;
    logic                      rstn;
    logic                      flush;
    logic [31:0]               redirect_pc;
    logic                      resp_valid;
    fetch_pkg::icache_resp_t   resp;
    logic                      pop;
    logic                      req_valid;
    fetch_pkg::fetch_req_t     fetch_req;
    logic                      bundle_valid;
    fetch_pkg::fetch_bundle_t  bundle;
    int error_count;
    int bundle_count;
    int request_count;

    // controls, written on the rising edge and read on the falling edge
    logic        flush_req = 1'b0;
    logic [31:0] flush_target = '0;
    int          pop_pct = 0;
    int          flush_pct = 0;
    int          tb_errors = 0;
    int unsigned cycle = 0;
    // due cycle of each request the cache still owes
    int unsigned due_q[$];

    tb_clock #(.period(40)) u_tb_clock (.clk(clk));

    fetch_frontend #(
        .reset_pc (reset_pc),
        .pc_depth (pc_depth),
        .iq_depth (iq_depth)
    ) u_fetch_frontend (
        .clk          (clk),
        .rstn         (rstn),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .pop          (pop),
        .req_valid    (req_valid),
        .fetch_req    (fetch_req),
        .bundle_valid (bundle_valid),
        .bundle       (bundle)
    );

    fetch_checker #(
        .reset_pc (reset_pc),
        .pc_depth (pc_depth),
        .iq_depth (iq_depth)
    ) u_fetch_checker (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .redirect_pc   (redirect_pc),
        .resp_valid    (resp_valid),
        .resp          (resp),
        .pop           (pop),
        .req_valid     (req_valid),
        .fetch_req     (fetch_req),
        .bundle_valid  (bundle_valid),
        .bundle        (bundle),
        .error_count   (error_count),
        .bundle_count  (bundle_count),
        .request_count (request_count)
    );

    // cycle count and timeout, cache takes each request with a 1 to 4 cycle latency
    always @(posedge clk) begin
        cycle++;
        if (cycle > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d bundles popped",
                     cycle, bundle_count, total_bundles);
            $display("TEST FAILED");
            $finish;
        end else if (rstn && req_valid) begin
            due_q.push_back(cycle + $urandom_range(4, 1));
        end
    end

    // cache, decoder and flush models, all driven on the falling edge
    always @(negedge clk) begin : drive
        logic take_flush;
        if (cycle != 0) begin
            take_flush = flush_req || (int'($urandom_range(99)) < flush_pct);
            if (take_flush) begin
                flush = 1'b1;
                if (flush_req) begin
                    redirect_pc = flush_target;
                end else begin
                    redirect_pc = 32'h1c00_0000 | (32'($urandom) & 32'h000f_fffc);
                end
                resp_valid = 1'b0;
                // cache drops whatever was asked before the flush
                due_q.delete();
                flush_req = 1'b0;
            end else begin
                flush = 1'b0;
                // in order, at most one answer per cycle
                if (due_q.size() > 0 && due_q[0] <= cycle + 1) begin
                    void'(due_q.pop_front());
                    resp_valid = 1'b1;
                    resp.inst0 = $urandom;
                    resp.inst1 = $urandom;
                    resp.badv = $urandom;
                    resp.excp_flag = 2'($urandom_range(3));
                    // exception code only now and then
                    resp.excp_code = ($urandom_range(7) == 0) ? 7'($urandom_range(127, 1)) : 7'd0;
                end else begin
                    resp_valid = 1'b0;
                end
            end
            pop = (int'($urandom_range(99)) < pop_pct);
        end
    end

    task automatic wait_bundles(input int n);
        int target;
        target = bundle_count + n;
        while (bundle_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic request_flush(input logic [31:0] target);
        flush_target = target;
        flush_req = 1'b1;
        while (flush_req) begin
            @(posedge clk);
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start, input int b_at_start);
        $display("test %s: %0d bundles, %0d errors", name, bundle_count - b_at_start,
                 error_count + tb_errors - errs_at_start);
    endtask

    initial begin
        int errs0;
        int b0;
        rstn = 1'b0;
        flush = 1'b0;
        redirect_pc = '0;
        resp_valid = 1'b0;
        resp = '0;
        pop = 1'b0;
        void'($urandom(50));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(posedge clk);

        // first pc is the reset pc, then aligned steps of 8
        errs0 = error_count + tb_errors;
        b0 = bundle_count;
        pop_pct = 80;
        wait_bundles(n_start);
        end_test("reset_and_step", errs0, b0);

        // redirect into the upper half of a block
        errs0 = error_count + tb_errors;
        b0 = bundle_count;
        pop_pct = 70;
        request_flush(32'h1c00_2004);
        wait_bundles(n_redirect);
        end_test("redirect_upper_half", errs0, b0);

        // random latency, random pops and random flushes
        errs0 = error_count + tb_errors;
        b0 = bundle_count;
        pop_pct = 60;
        flush_pct = 2;
        wait_bundles(n_random);
        flush_pct = 0;
        end_test("random_traffic", errs0, b0);

        // decoder stalled, fetch must stop short of overflow
        errs0 = error_count + tb_errors;
        b0 = bundle_count;
        pop_pct = 0;
        repeat (40) @(posedge clk);
        if (req_valid !== 1'b0) begin
            $display("FAIL time %0t req_valid expected 0 actual %b", $time, req_valid);
            tb_errors++;
        end
        if (bundle_valid !== 1'b1) begin
            $display("FAIL time %0t bundle_valid expected 1 actual %b", $time, bundle_valid);
            tb_errors++;
        end
        pop_pct = 70;
        wait_bundles(n_stall);
        end_test("decoder_stall", errs0, b0);

        // flush with bundles still queued
        errs0 = error_count + tb_errors;
        b0 = bundle_count;
        pop_pct = 0;
        repeat (12) @(posedge clk);
        request_flush(32'h1c00_8000);
        pop_pct = 75;
        wait_bundles(n_flush);
        end_test("flush_drops_old", errs0, b0);

        @(negedge clk);
        $display("summary: %0d bundles, %0d requests, %0d errors",
                 bundle_count, request_count, error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int period = 40
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire
